// File: common/ex_pkg.sv
package ex_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////////////////////////

    localparam int xlen         = 32;
    localparam int rob_idx_bits = 5;
    localparam int reg_idx_bits = 5;

    //////////////////////////////////////////////////////////////////////
    // encodings
    //////////////////////////////////////////////////////////////////////

    // values double as waiting-flag positions in the arbiter
    typedef enum logic [1:0] {
        FU_ALU    = 2'd0,
        FU_MULT   = 2'd1,
        FU_BRANCH = 2'd2
    } fu_kind_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_MUL,
        ALU_MULHU
    } alu_func_e;

    typedef enum logic [1:0] {
        OPA_IS_RS1,
        OPA_IS_NPC,
        OPA_IS_PC,
        OPA_IS_ZERO
    } opa_sel_e;

    typedef enum logic [2:0] {
        OPB_IS_RS2,
        OPB_IS_I_IMM,
        OPB_IS_S_IMM,
        OPB_IS_B_IMM,
        OPB_IS_U_IMM,
        OPB_IS_J_IMM
    } opb_sel_e;

    typedef enum logic [1:0] {
        MS_IDLE,
        MS_RUN,
        MS_DONE
    } mult_state_e;

    //////////////////////////////////////////////////////////////////////
    // packets
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [rob_idx_bits-1:0] rob_index;
        logic [reg_idx_bits-1:0] dest_reg_idx;
    } tag_t;

    typedef struct packed {
        logic            valid;
        fu_kind_e        fu_kind;
        alu_func_e       alu_func;
        opa_sel_e        opa_select;
        opb_sel_e        opb_select;
        logic [31:0]     inst;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] npc;
        logic [xlen-1:0] rs1_value;
        logic [xlen-1:0] rs2_value;
        logic            cond_branch;
        logic            uncond_branch;
        tag_t            tag;
    } issue_packet_t;

    // handed from each unit to the arbiter
    typedef struct packed {
        logic            done;
        logic [xlen-1:0] result;
        logic            take_branch;
        tag_t            tag;
    } unit_result_t;

    typedef struct packed {
        logic            valid;
        fu_kind_e        fu_kind;
        logic [xlen-1:0] result;
        logic            take_branch;
        tag_t            tag;
    } ex_result_t;

    //////////////////////////////////////////////////////////////////////
    // sign-extended immediates, rv32 formats
    //////////////////////////////////////////////////////////////////////

    function automatic logic [xlen-1:0] i_imm(input logic [31:0] inst);
        return {{20{inst[31]}}, inst[31:20]};
    endfunction

    function automatic logic [xlen-1:0] s_imm(input logic [31:0] inst);
        return {{20{inst[31]}}, inst[31:25], inst[11:7]};
    endfunction

    function automatic logic [xlen-1:0] b_imm(input logic [31:0] inst);
        return {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    endfunction

    function automatic logic [xlen-1:0] u_imm(input logic [31:0] inst);
        return {inst[31:12], 12'b0};
    endfunction

    function automatic logic [xlen-1:0] j_imm(input logic [31:0] inst);
        return {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    endfunction

endpackage

// File: dv/ex_stage_tb.sv
module ex_stage_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int num_packets     = 200;
    localparam int timeout_cycles  = num_packets * 8 + 100;
    // cycles from a multiply issue to its done at 8 bits per step
    localparam int mult_done_delay = ex_pkg::xlen / 8 + 1;

    logic                  clock;
    logic                  reset;
    ex_pkg::issue_packet_t issue;
    ex_pkg::ex_result_t    ex_out;
    logic                  free_alu;
    logic                  free_mult;
    logic                  free_branch;

    // scoreboard keyed by rob index
    logic [31:0]             sb_live = '0;
    logic [ex_pkg::xlen-1:0] sb_result [32];
    logic [31:0]             sb_take;
    logic [4:0]              sb_dest [32];
    logic [2:0]              busy = '0;
    logic                    seen_issue = 1'b0;
    logic [4:0]              next_rob;
    int                      issued_count = 0;
    int                      received_count = 0;
    int                      assert_errors = 0;
    int                      final_errors = 0;
    int                      cycle_count = 0;

    // expected completion order
    logic [2:0]       m_wait;
    logic             m_gv;
    ex_pkg::fu_kind_e m_gk;
    logic [4:0]       m_held [3];
    logic [4:0]       m_mult_rob;
    int               m_cnt = 0;
    logic [4:0]       exp_rob;
    logic [2:0]       exp_free;

    assign exp_rob  = m_held[m_gk];
    assign exp_free = m_gv ? (3'b001 << m_gk) : 3'b000;

    ex_stage #(
        .mult_bits_per_step (8)
    ) u_dut (
        .clock       (clock),
        .reset       (reset),
        .issue       (issue),
        .ex_out      (ex_out),
        .free_alu    (free_alu),
        .free_mult   (free_mult),
        .free_branch (free_branch)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("TIMEOUT: run did not finish within %0d cycles", timeout_cycles);
            $display("checks done: %0d issued, %0d received, %0d assertion errors",
                     issued_count, received_count, assert_errors);
            $display("Simulation failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    function automatic void expect_for(input ex_pkg::issue_packet_t p,
                                       output logic [ex_pkg::xlen-1:0] res,
                                       output logic take);
        logic [31:0] a;
        logic [31:0] b;
        logic [63:0] prod;
        logic        cmp;
        a = (p.opa_select == ex_pkg::OPA_IS_RS1) ? p.rs1_value :
            (p.opa_select == ex_pkg::OPA_IS_NPC) ? p.npc :
            (p.opa_select == ex_pkg::OPA_IS_PC)  ? p.pc : 32'h0;
        case (p.opb_select)
            ex_pkg::OPB_IS_RS2:   b = p.rs2_value;
            ex_pkg::OPB_IS_I_IMM: b = ex_pkg::i_imm(p.inst);
            ex_pkg::OPB_IS_S_IMM: b = ex_pkg::s_imm(p.inst);
            ex_pkg::OPB_IS_B_IMM: b = ex_pkg::b_imm(p.inst);
            ex_pkg::OPB_IS_U_IMM: b = ex_pkg::u_imm(p.inst);
            ex_pkg::OPB_IS_J_IMM: b = ex_pkg::j_imm(p.inst);
            default:              b = 32'h0;
        endcase
        res  = 32'h0;
        take = 1'b0;
        if (p.fu_kind == ex_pkg::FU_MULT) begin
            prod = {32'h0, a} * {32'h0, b};
            res  = (p.alu_func == ex_pkg::ALU_MULHU) ? prod[63:32] : prod[31:0];
        end else if (p.fu_kind == ex_pkg::FU_BRANCH) begin
            res = (a + b) & 32'hffff_fffe;
            case (p.inst[14:12])
                3'd0:    cmp = p.rs1_value == p.rs2_value;
                3'd1:    cmp = p.rs1_value != p.rs2_value;
                3'd4:    cmp = $signed(p.rs1_value) < $signed(p.rs2_value);
                3'd5:    cmp = !($signed(p.rs1_value) < $signed(p.rs2_value));
                3'd6:    cmp = p.rs1_value < p.rs2_value;
                3'd7:    cmp = !(p.rs1_value < p.rs2_value);
                default: cmp = 1'b0;
            endcase
            take = p.uncond_branch || (p.cond_branch && cmp);
        end else begin
            case (p.alu_func)
                ex_pkg::ALU_ADD:  res = a + b;
                ex_pkg::ALU_SUB:  res = a - b;
                ex_pkg::ALU_AND:  res = a & b;
                ex_pkg::ALU_OR:   res = a | b;
                ex_pkg::ALU_XOR:  res = a ^ b;
                ex_pkg::ALU_SLT:  res = {31'h0, $signed(a) < $signed(b)};
                ex_pkg::ALU_SLTU: res = {31'h0, a < b};
                ex_pkg::ALU_SLL:  res = a << b[4:0];
                ex_pkg::ALU_SRL:  res = a >> b[4:0];
                ex_pkg::ALU_SRA:  res = $signed(a) >>> b[4:0];
                default:          res = 32'h0;
            endcase
        end
    endfunction

    // alu and branch finish in the issue cycle and the multiplier later
    // grants go to alu before mult before branch
    always @(posedge clock) begin : completion_model
        logic [2:0] done_now;
        logic [2:0] grant;
        done_now = 3'b000;
        grant    = 3'b000;
        if (m_wait[0]) begin
            grant = 3'b001;
        end else if (m_wait[1]) begin
            grant = 3'b010;
        end else if (m_wait[2]) begin
            grant = 3'b100;
        end
        if (issue.valid && issue.fu_kind == ex_pkg::FU_ALU) begin
            done_now[0] = 1'b1;
            m_held[0]  <= issue.tag.rob_index;
        end
        if (issue.valid && issue.fu_kind == ex_pkg::FU_BRANCH) begin
            done_now[2] = 1'b1;
            m_held[2]  <= issue.tag.rob_index;
        end
        if (m_cnt == 1) begin
            done_now[1] = 1'b1;
            m_held[1]  <= m_mult_rob;
        end
        if (reset) begin
            m_wait <= 3'b000;
            m_gv   <= 1'b0;
            m_gk   <= ex_pkg::FU_ALU;
            m_cnt  <= 0;
        end else begin
            m_wait <= (m_wait & ~grant) | done_now;
            m_gv   <= (grant != 3'b000);
            m_gk   <= grant[0] ? ex_pkg::FU_ALU : (grant[1] ? ex_pkg::FU_MULT : ex_pkg::FU_BRANCH);
            if (issue.valid && issue.fu_kind == ex_pkg::FU_MULT) begin
                m_cnt      <= mult_done_delay;
                m_mult_rob <= issue.tag.rob_index;
            end else if (m_cnt > 0) begin
                m_cnt <= m_cnt - 1;
            end
        end
    end

    // runs just after the negedge checks have sampled the scoreboard
    always begin : bookkeeping
        logic [ex_pkg::xlen-1:0] res;
        logic                    take;
        @(negedge clock);
        #1;
        if (!reset) begin
            if (ex_out.valid) begin
                sb_live[ex_out.tag.rob_index] = 1'b0;
                received_count = received_count + 1;
            end
            busy = busy & ~{free_branch, free_mult, free_alu};
            if (issue.valid) begin
                expect_for(issue, res, take);
                sb_result[issue.tag.rob_index] = res;
                sb_take[issue.tag.rob_index]   = take;
                sb_dest[issue.tag.rob_index]   = issue.tag.dest_reg_idx;
                sb_live[issue.tag.rob_index]   = 1'b1;
                busy[issue.fu_kind]            = 1'b1;
                issued_count = issued_count + 1;
                seen_issue   = 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    quiet_check: assert property (@(negedge clock) (reset || !seen_issue) |->
        !(ex_out.valid || free_alu || free_mult || free_branch))
    else begin
        assert_errors = assert_errors + 1;
        $display("%0t: output or free strobe active before the first issue", $time);
    end

    valid_check: assert property (@(negedge clock) disable iff (reset) ex_out.valid == m_gv)
    else begin
        assert_errors = assert_errors + 1;
        $display("ERROR: %0t ex_out.valid expected %b actual %b", $time, m_gv, ex_out.valid);
    end

    kind_check: assert property (@(negedge clock) disable iff (reset)
        ex_out.valid |-> ex_out.fu_kind == m_gk)
    else begin
        assert_errors = assert_errors + 1;
        $display("ERROR: %0t ex_out.fu_kind expected %0d actual %0d",
                 $time, m_gk, ex_out.fu_kind);
    end

    rob_check: assert property (@(negedge clock) disable iff (reset)
        ex_out.valid |-> ex_out.tag.rob_index == exp_rob)
    else begin
        assert_errors = assert_errors + 1;
        $display("ERROR: %0t ex_out.tag.rob_index expected %0d actual %0d",
                 $time, exp_rob, ex_out.tag.rob_index);
    end

    live_check: assert property (@(negedge clock) disable iff (reset)
        ex_out.valid |-> sb_live[ex_out.tag.rob_index])
    else begin
        assert_errors = assert_errors + 1;
        $display("%0t: result for rob index %0d with no packet outstanding",
                 $time, ex_out.tag.rob_index);
    end

    result_check: assert property (@(negedge clock) disable iff (reset)
        ex_out.valid |-> ex_out.result == sb_result[ex_out.tag.rob_index])
    else begin
        assert_errors = assert_errors + 1;
        $display("ERROR: %0t ex_out.result expected %h actual %h",
                 $time, sb_result[ex_out.tag.rob_index], ex_out.result);
    end

    take_check: assert property (@(negedge clock) disable iff (reset)
        ex_out.valid |-> ex_out.take_branch == sb_take[ex_out.tag.rob_index])
    else begin
        assert_errors = assert_errors + 1;
        $display("ERROR: %0t ex_out.take_branch expected %b actual %b",
                 $time, sb_take[ex_out.tag.rob_index], ex_out.take_branch);
    end

    dest_check: assert property (@(negedge clock) disable iff (reset)
        ex_out.valid |-> ex_out.tag.dest_reg_idx == sb_dest[ex_out.tag.rob_index])
    else begin
        assert_errors = assert_errors + 1;
        $display("ERROR: %0t ex_out.tag.dest_reg_idx expected %0d actual %0d",
                 $time, sb_dest[ex_out.tag.rob_index], ex_out.tag.dest_reg_idx);
    end

    free_check: assert property (@(negedge clock) disable iff (reset)
        {free_branch, free_mult, free_alu} == exp_free)
    else begin
        assert_errors = assert_errors + 1;
        $display("ERROR: %0t free strobes expected %b actual %b",
                 $time, exp_free, {free_branch, free_mult, free_alu});
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic build_packet(input ex_pkg::fu_kind_e kind, output ex_pkg::issue_packet_t pkt);
        int pick;
        pkt                  = '0;
        pkt.valid            = 1'b1;
        pkt.fu_kind          = kind;
        pkt.inst             = $urandom;
        pkt.pc               = $urandom & 32'hffff_fffc;
        pkt.npc              = pkt.pc + 32'd4;
        pkt.rs1_value        = $urandom;
        // equal operands now and then for the branch compares
        pkt.rs2_value        = (($urandom % 4) == 0) ? pkt.rs1_value : $urandom;
        pkt.tag.dest_reg_idx = 5'($urandom);
        while (sb_live[next_rob]) begin
            next_rob = next_rob + 5'd1;
        end
        pkt.tag.rob_index = next_rob;
        next_rob          = next_rob + 5'd1;
        pick              = $urandom % 4;
        if (kind == ex_pkg::FU_ALU) begin
            pkt.alu_func   = ex_pkg::alu_func_e'(4'($urandom % 10));
            pkt.opa_select = ex_pkg::opa_sel_e'(2'($urandom));
            pkt.opb_select = (pick == 0) ? ex_pkg::OPB_IS_RS2 :
                             (pick == 1) ? ex_pkg::OPB_IS_I_IMM :
                             (pick == 2) ? ex_pkg::OPB_IS_S_IMM : ex_pkg::OPB_IS_U_IMM;
            if (pick >= 2) begin
                pkt.alu_func = ex_pkg::ALU_ADD;
            end
        end else if (kind == ex_pkg::FU_MULT) begin
            pkt.alu_func   = pick[0] ? ex_pkg::ALU_MULHU : ex_pkg::ALU_MUL;
            pkt.opa_select = ex_pkg::OPA_IS_RS1;
            pkt.opb_select = ex_pkg::OPB_IS_RS2;
        end else begin
            pkt.opa_select    = ex_pkg::OPA_IS_PC;
            pkt.uncond_branch = (pick == 0);
            pkt.cond_branch   = (pick != 0);
            pkt.opb_select    = (pick == 0) ? ex_pkg::OPB_IS_J_IMM : ex_pkg::OPB_IS_B_IMM;
        end
    endtask

    initial begin : stimulus
        ex_pkg::issue_packet_t pkt;
        ex_pkg::fu_kind_e      kind;
        int                    sent;
        int                    first;
        logic                  found;
        void'($urandom(32'h77a5));
        reset    = 1'b1;
        issue    = '0;
        next_rob = 5'd0;
        repeat (5) @(posedge clock);
        #2;
        reset = 1'b0;

        // alu issued in the multiplier's done cycle and branch right after
        // so alu meets mult and then mult meets branch at the arbiter
        @(posedge clock);
        #2;
        build_packet(ex_pkg::FU_MULT, pkt);
        issue = pkt;
        repeat (4) begin
            @(posedge clock);
            #2;
            issue = '0;
        end
        @(posedge clock);
        #2;
        build_packet(ex_pkg::FU_ALU, pkt);
        issue = pkt;
        @(posedge clock);
        #2;
        build_packet(ex_pkg::FU_BRANCH, pkt);
        issue = pkt;
        sent  = 3;

        while (sent < num_packets) begin
            @(posedge clock);
            #2;
            first = $urandom % 3;
            found = 1'b0;
            kind  = ex_pkg::FU_ALU;
            for (int i = 0; i < 3; i++) begin
                if (!found && !busy[(first + i) % 3]) begin
                    kind  = ex_pkg::fu_kind_e'(2'((first + i) % 3));
                    found = 1'b1;
                end
            end
            if (!found || ($urandom % 4) == 0) begin
                issue = '0;
            end else begin
                build_packet(kind, pkt);
                issue = pkt;
                sent  = sent + 1;
            end
        end
        @(posedge clock);
        #2;
        issue = '0;
        while (sb_live != 32'h0) begin
            @(posedge clock);
        end
        repeat (4) @(posedge clock);

        if (issued_count != num_packets || received_count != issued_count) begin
            final_errors = final_errors + 1;
            $display("issued %0d packets but received %0d results", issued_count, received_count);
        end
        $display("checks done: %0d issued, %0d received, %0d assertion errors, %0d other errors",
                 issued_count, received_count, assert_errors, final_errors);
        if (assert_errors == 0 && final_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: multiply/mult_datapath.sv
module mult_datapath #(
    parameter int mult_bits_per_step = 8
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    load,
    input  logic                    step,
    input  logic                    finish,
    input  logic [ex_pkg::xlen-1:0] opa,
    input  logic [ex_pkg::xlen-1:0] opb,
    input  ex_pkg::tag_t            tag,
    input  logic                    high_half,
    output ex_pkg::unit_result_t    mult_out
);

    localparam int w = ex_pkg::xlen;
    localparam int k = mult_bits_per_step;

    logic [w-1:0]   mcand;
    logic [w-1:0]   mplier;
    logic [2*w-1:0] product;
    logic [w+k-1:0] partial;
    logic [w+k-1:0] upper_sum;

    // next k multiplier bits against the multiplicand
    assign partial   = mcand * mplier[k-1:0];
    // fits in w+k bits, the low bits of the product are still being shifted in
    assign upper_sum = partial + product[2*w-1:w];

    always_ff @(posedge clock) begin
        if (load) begin
            mcand  <= opa;
            mplier <= opb;
        end else if (step) begin
            mplier <= mplier >> k;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            product <= '0;
        end else if (load) begin
            product <= '0;
        end else if (step) begin
            product <= {upper_sum, product[w-1:k]};
        end
    end

    always_comb begin
        mult_out.done        = finish;
        mult_out.result      = high_half ? product[2*w-1:w] : product[w-1:0];
        mult_out.take_branch = 1'b0;
        mult_out.tag         = tag;
    end

endmodule

// File: multiply/mult_fsm.sv
module mult_fsm #(
    parameter int mult_bits_per_step = 8
) (
    input  logic                  clock,
    input  logic                  reset,
    input  ex_pkg::issue_packet_t issue,
    output logic                  load,
    output logic                  step,
    output logic                  finish,
    output ex_pkg::tag_t          tag,
    output logic                  high_half
);

    localparam int num_steps  = ex_pkg::xlen / mult_bits_per_step;
    localparam int count_bits = (num_steps > 1) ? $clog2(num_steps) : 1;

    ex_pkg::mult_state_e   state;
    ex_pkg::mult_state_e   next_state;
    logic [count_bits-1:0] step_count;
    logic                  last_step;

    assign load      = (state == ex_pkg::MS_IDLE) && issue.valid &&
                       (issue.fu_kind == ex_pkg::FU_MULT);
    assign step      = (state == ex_pkg::MS_RUN);
    assign finish    = (state == ex_pkg::MS_DONE);
    assign last_step = (step_count == count_bits'(num_steps - 1));

    always_comb begin
        next_state = state;
        case (state)
            ex_pkg::MS_IDLE: begin
                if (load) begin
                    next_state = ex_pkg::MS_RUN;
                end
            end
            ex_pkg::MS_RUN: begin
                if (last_step) begin
                    next_state = ex_pkg::MS_DONE;
                end
            end
            ex_pkg::MS_DONE: begin
                // done is a single cycle
                next_state = ex_pkg::MS_IDLE;
            end
            default: begin
                next_state = ex_pkg::MS_IDLE;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= ex_pkg::MS_IDLE;
            step_count <= '0;
        end else begin
            state <= next_state;
            if (load) begin
                step_count <= '0;
            end else if (step) begin
                step_count <= step_count + 1'b1;
            end
        end
    end

    // tag and half select ride along with the operation
    always_ff @(posedge clock) begin
        if (load) begin
            tag       <= issue.tag;
            high_half <= (issue.alu_func == ex_pkg::ALU_MULHU);
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# build and run the ex_stage testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module ex_stage_tb -Mdir obj_dir \
    -f src.f > build.log 2>&1 \
    && ./obj_dir/Vex_stage_tb > sim.log 2>&1 \
    && grep -q "Simulation completed successfully" sim.log \
    && echo "PASS, see sim.log" \
    || { echo "FAIL, see build.log and sim.log"; exit 1; }

// File: source/branch_unit.sv
module branch_unit (
    input  ex_pkg::issue_packet_t       issue,
    input  logic [ex_pkg::xlen-1:0]     opa,
    input  logic [ex_pkg::xlen-1:0]     opb,
    output ex_pkg::unit_result_t        branch_out
);

    logic [2:0]              funct3;
    logic                    cond_met;
    logic [ex_pkg::xlen-1:0] target_sum;

    assign funct3     = issue.inst[14:12];
    assign target_sum = opa + opb;

    // comparison picked by funct3 of the b-type encoding
    always_comb begin
        case (funct3)
            3'b000: begin
                cond_met = issue.rs1_value == issue.rs2_value;
            end
            3'b001: begin
                cond_met = issue.rs1_value != issue.rs2_value;
            end
            3'b100: begin
                cond_met = $signed(issue.rs1_value) < $signed(issue.rs2_value);
            end
            3'b101: begin
                cond_met = $signed(issue.rs1_value) >= $signed(issue.rs2_value);
            end
            3'b110: begin
                cond_met = issue.rs1_value < issue.rs2_value;
            end
            3'b111: begin
                cond_met = issue.rs1_value >= issue.rs2_value;
            end
            default: begin
                cond_met = 1'b0;
            end
        endcase
    end

    always_comb begin
        branch_out.done        = issue.valid && (issue.fu_kind == ex_pkg::FU_BRANCH);
        // target is halfword aligned
        branch_out.result      = {target_sum[ex_pkg::xlen-1:1], 1'b0};
        branch_out.take_branch = issue.uncond_branch || (issue.cond_branch && cond_met);
        branch_out.tag         = issue.tag;
    end

endmodule

// File: source/completion_arbiter.sv
module completion_arbiter (
    input  logic                 clock,
    input  logic                 reset,
    input  ex_pkg::unit_result_t alu_in,
    input  ex_pkg::unit_result_t mult_in,
    input  ex_pkg::unit_result_t branch_in,
    output ex_pkg::ex_result_t   ex_out,
    output logic                 free_alu,
    output logic                 free_mult,
    output logic                 free_branch
);

    localparam int num_units = 3;

    ex_pkg::unit_result_t   unit_in [num_units];
    ex_pkg::unit_result_t   held [num_units];
    logic [num_units-1:0]   done_mask;
    logic [num_units-1:0]   waiting;
    logic [num_units-1:0]   grant_mask;
    logic                   pick_valid;
    ex_pkg::fu_kind_e       pick_kind;
    logic                   grant_valid;
    ex_pkg::fu_kind_e       grant_kind;

    // slots indexed by unit kind
    always_comb begin
        unit_in[ex_pkg::FU_ALU]    = alu_in;
        unit_in[ex_pkg::FU_MULT]   = mult_in;
        unit_in[ex_pkg::FU_BRANCH] = branch_in;
        for (int u = 0; u < num_units; u++) begin
            done_mask[u] = unit_in[u].done;
        end
    end

    always_ff @(posedge clock) begin
        for (int u = 0; u < num_units; u++) begin
            if (unit_in[u].done) begin
                held[u] <= unit_in[u];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // fixed priority: alu, mult, branch
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        pick_valid = |waiting;
        pick_kind  = ex_pkg::FU_ALU;
        grant_mask = '0;
        if (waiting[ex_pkg::FU_ALU]) begin
            pick_kind = ex_pkg::FU_ALU;
        end else if (waiting[ex_pkg::FU_MULT]) begin
            pick_kind = ex_pkg::FU_MULT;
        end else if (waiting[ex_pkg::FU_BRANCH]) begin
            pick_kind = ex_pkg::FU_BRANCH;
        end
        if (pick_valid) begin
            grant_mask[pick_kind] = 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            waiting     <= '0;
            grant_valid <= 1'b0;
            grant_kind  <= ex_pkg::FU_ALU;
        end else begin
            // a new done wins over the grant clear
            waiting     <= (waiting & ~grant_mask) | done_mask;
            grant_valid <= pick_valid;
            grant_kind  <= pick_kind;
        end
    end

    // output from the held slot of the registered grant
    always_comb begin
        ex_out.valid       = grant_valid;
        ex_out.fu_kind     = grant_kind;
        ex_out.result      = held[grant_kind].result;
        ex_out.take_branch = held[grant_kind].take_branch;
        ex_out.tag         = held[grant_kind].tag;
    end

    assign free_alu    = grant_valid && (grant_kind == ex_pkg::FU_ALU);
    assign free_mult   = grant_valid && (grant_kind == ex_pkg::FU_MULT);
    assign free_branch = grant_valid && (grant_kind == ex_pkg::FU_BRANCH);

endmodule

// File: source/ex_stage.sv
module ex_stage #(
    parameter int mult_bits_per_step = 8
) (
    input  logic                  clock,
    input  logic                  reset,
    input  ex_pkg::issue_packet_t issue,
    output ex_pkg::ex_result_t    ex_out,
    output logic                  free_alu,
    output logic                  free_mult,
    output logic                  free_branch
);

    logic [ex_pkg::xlen-1:0] opa;
    logic [ex_pkg::xlen-1:0] opb;
    ex_pkg::unit_result_t    alu_res;
    ex_pkg::unit_result_t    branch_res;
    ex_pkg::unit_result_t    mult_res;
    logic                    mult_load;
    logic                    mult_step;
    logic                    mult_finish;
    ex_pkg::tag_t            mult_tag;
    logic                    mult_high_half;

    operand_select u_operand_select (
        .issue (issue),
        .opa   (opa),
        .opb   (opb)
    );

    int_alu u_int_alu (
        .issue   (issue),
        .opa     (opa),
        .opb     (opb),
        .alu_out (alu_res)
    );

    branch_unit u_branch_unit (
        .issue      (issue),
        .opa        (opa),
        .opb        (opb),
        .branch_out (branch_res)
    );

    //////////////////////////////////////////////////////////////////////
    // iterative multiplier
    //////////////////////////////////////////////////////////////////////

    mult_fsm #(
        .mult_bits_per_step (mult_bits_per_step)
    ) u_mult_fsm (
        .clock     (clock),
        .reset     (reset),
        .issue     (issue),
        .load      (mult_load),
        .step      (mult_step),
        .finish    (mult_finish),
        .tag       (mult_tag),
        .high_half (mult_high_half)
    );

    mult_datapath #(
        .mult_bits_per_step (mult_bits_per_step)
    ) u_mult_datapath (
        .clock     (clock),
        .reset     (reset),
        .load      (mult_load),
        .step      (mult_step),
        .finish    (mult_finish),
        .opa       (opa),
        .opb       (opb),
        .tag       (mult_tag),
        .high_half (mult_high_half),
        .mult_out  (mult_res)
    );

    completion_arbiter u_completion_arbiter (
        .clock       (clock),
        .reset       (reset),
        .alu_in      (alu_res),
        .mult_in     (mult_res),
        .branch_in   (branch_res),
        .ex_out      (ex_out),
        .free_alu    (free_alu),
        .free_mult   (free_mult),
        .free_branch (free_branch)
    );

endmodule

// File: source/int_alu.sv
module int_alu (
    input  ex_pkg::issue_packet_t       issue,
    input  logic [ex_pkg::xlen-1:0]     opa,
    input  logic [ex_pkg::xlen-1:0]     opb,
    output ex_pkg::unit_result_t        alu_out
);

    logic [4:0]              shamt;
    logic [ex_pkg::xlen-1:0] alu_result;

    assign shamt = opb[4:0];

    always_comb begin
        alu_result = '0;
        case (issue.alu_func)
            ex_pkg::ALU_ADD:  alu_result = opa + opb;
            ex_pkg::ALU_SUB:  alu_result = opa - opb;
            ex_pkg::ALU_AND:  alu_result = opa & opb;
            ex_pkg::ALU_OR:   alu_result = opa | opb;
            ex_pkg::ALU_XOR:  alu_result = opa ^ opb;
            ex_pkg::ALU_SLT: begin
                alu_result[0] = $signed(opa) < $signed(opb);
            end
            ex_pkg::ALU_SLTU: begin
                alu_result[0] = opa < opb;
            end
            ex_pkg::ALU_SLL:  alu_result = opa << shamt;
            ex_pkg::ALU_SRL:  alu_result = opa >> shamt;
            ex_pkg::ALU_SRA:  alu_result = $signed(opa) >>> shamt;
            default: begin
                // multiply opcodes belong to the multiplier
                alu_result = '0;
            end
        endcase
    end

    // single cycle, done in the issue cycle
    always_comb begin
        alu_out.done        = issue.valid && (issue.fu_kind == ex_pkg::FU_ALU);
        alu_out.result      = alu_result;
        alu_out.take_branch = 1'b0;
        alu_out.tag         = issue.tag;
    end

endmodule

// File: source/operand_select.sv
module operand_select (
    input  ex_pkg::issue_packet_t       issue,
    output logic [ex_pkg::xlen-1:0]     opa,
    output logic [ex_pkg::xlen-1:0]     opb
);

    // operand a
    always_comb begin
        case (issue.opa_select)
            ex_pkg::OPA_IS_RS1: begin
                opa = issue.rs1_value;
            end
            ex_pkg::OPA_IS_NPC: begin
                opa = issue.npc;
            end
            ex_pkg::OPA_IS_PC: begin
                opa = issue.pc;
            end
            default: begin
                opa = '0;
            end
        endcase
    end

    // operand b, register or one of the immediates in inst
    always_comb begin
        case (issue.opb_select)
            ex_pkg::OPB_IS_RS2: begin
                opb = issue.rs2_value;
            end
            ex_pkg::OPB_IS_I_IMM: begin
                opb = ex_pkg::i_imm(issue.inst);
            end
            ex_pkg::OPB_IS_S_IMM: begin
                opb = ex_pkg::s_imm(issue.inst);
            end
            ex_pkg::OPB_IS_B_IMM: begin
                opb = ex_pkg::b_imm(issue.inst);
            end
            ex_pkg::OPB_IS_U_IMM: begin
                opb = ex_pkg::u_imm(issue.inst);
            end
            ex_pkg::OPB_IS_J_IMM: begin
                opb = ex_pkg::j_imm(issue.inst);
            end
            default: begin
                // encodings 6 and 7 are unused
                opb = '0;
            end
        endcase
    end

endmodule

// File: src.f
common/ex_pkg.sv
source/operand_select.sv
source/int_alu.sv
source/branch_unit.sv
multiply/mult_fsm.sv
multiply/mult_datapath.sv
source/completion_arbiter.sv
source/ex_stage.sv
dv/ex_stage_tb.sv
